// File: files.f
verilog/sprite_pkg.sv
verilog/sprite_shifter.sv
verilog/sprite_priority.sv
verilog/denise_sprites.sv
verilog/sprite_display.sv
testbench/tb_sprite_display.sv

// File: run_sim.sh
#!/bin/sh
# build the sprite display testbench with Verilator and run it
# exit status is the simulator's, nonzero when the testbench fails

cd "$(dirname "$0")" || exit 1

TOP=tb_sprite_display
OBJ=obj_dir

verilator --binary --timing --assert \
	--top-module "$TOP" -Mdir "$OBJ" -f files.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

if [ ! -x "./$OBJ/V$TOP" ]; then
	echo "simulation binary ./$OBJ/V$TOP not found"
	exit 1
fi

"./$OBJ/V$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// File: testbench/tb_sprite_display.sv
/*
 * Testbench for the sprite display top, built with Verilator --timing.
 * Register writes are made early in a line, before any sprite window,
 * so every hstart used here is 40 or more and ends before the line wraps.
 */

`timescale 1ns/10ps

module tb_sprite_display
	import sprite_pkg::*;
();

// ----------------------------------------------------------------------
// DUT signals
// ----------------------------------------------------------------------
logic       clk = 1'b0;
logic       rst = 1'b1;
reg_addr_t  reg_address_in = IDLE_ADDR[8:1];  // bus at rest
word_t      data_in = '0;
logic       sprena = 1'b1;
hpos_t      hpos;
spr_mask_t  nsprite;
spr_color_t sprdata;

// shadow model, one entry per sprite
hpos_t m_hstart [SPR_NUM];
logic  m_attach [SPR_NUM];
word_t m_a [SPR_NUM];
word_t m_b [SPR_NUM];
logic  m_armed [SPR_NUM];

spr_pix_t   exp_pix [SPR_NUM];  // predicted pixel per sprite
spr_mask_t  exp_mask;
spr_color_t exp_color;

integer seed = 32'hdcf5;
localparam int WAIT_LIMIT = 4 * LINE_LEN + 16;  // clk cycles, a bit over one line

always
	#10 clk = ~clk;  // 20 ns period

sprite_display uut
(
	.clk            (clk),
	.rst            (rst),
	.reg_address_in (reg_address_in),
	.data_in        (data_in),
	.sprena         (sprena),
	.hpos           (hpos),
	.nsprite        (nsprite),
	.sprdata        (sprdata)
);

// ----------------------------------------------------------------------
// expected outputs from the model and the beam
// ----------------------------------------------------------------------
always_comb
begin
	int n;
	logic [3:0] bit_idx;
	logic found;
	exp_mask = '0;
	exp_color = '0;  // transparent unless a pair is opaque
	found = 1'b0;
	for (int i = 0; i < SPR_NUM; i++)
	begin
		n = int'(hpos) - int'(m_hstart[i]) - 1;  // pixel number shown now
		bit_idx = 4'(15 - n);                     // msb first
		if (m_armed[i] && n >= 0 && n < 16)
			exp_pix[i] = {m_b[i][bit_idx], m_a[i][bit_idx]};
		else
			exp_pix[i] = 2'b00;
		exp_mask[i] = sprena && (exp_pix[i] != 2'b00);
	end
	// first opaque pair from the bottom takes the colour
	for (int p = 0; p < SPR_NUM / 2; p++)
	begin
		if (!found && (exp_mask[2*p] || exp_mask[2*p+1]))
		begin
			found = 1'b1;
			if (m_attach[2*p+1])
				exp_color = {exp_pix[2*p+1], exp_pix[2*p]};  // attached pair
			else if (exp_mask[2*p])
				exp_color = {2'(p), exp_pix[2*p]};
			else
				exp_color = {2'(p), exp_pix[2*p+1]};
		end
	end
end

// ----------------------------------------------------------------------
// helpers
// ----------------------------------------------------------------------
task stop_run(input string why);
	$display("%s", why);
	$display("TESTBENCH FAILED");
	$fatal(1, "run stopped at first error");
endtask

a_mask_match: assert property (@(posedge clk) disable iff (rst) nsprite == exp_mask)
	else stop_run($sformatf("CHECK FAILED at %0t: nsprite %b, expected %b, hpos %0d",
		$time, nsprite, exp_mask, hpos));

a_color_match: assert property (@(posedge clk) disable iff (rst) sprdata == exp_color)
	else stop_run($sformatf("CHECK FAILED at %0t: sprdata %h, expected %h, hpos %0d",
		$time, sprdata, exp_color, hpos));

// one register write, held 4 clk so a pixel tick lands inside
task write_reg(input int spr, input logic [1:0] r, input word_t d);
	logic [8:0] byte_addr;
	byte_addr = SPR_BASE + 9'(spr * 8) + {6'd0, r, 1'b0};
	@(posedge clk);
	reg_address_in <= byte_addr[8:1];
	data_in <= d;
	repeat (4) @(posedge clk);
	reg_address_in <= IDLE_ADDR[8:1];
	case (r)  // mirror into the model
		SPR_REG_POS:
			m_hstart[spr][8:1] = d[7:0];
		SPR_REG_CTL:
		begin
			m_hstart[spr][0] = d[0];
			m_attach[spr] = d[7];
			m_armed[spr] = 1'b0;  // ctl always disarms
		end
		SPR_REG_DATA:
		begin
			m_a[spr] = d;
			m_armed[spr] = 1'b1;
		end
		SPR_REG_DATB:
			m_b[spr] = d;
	endcase
endtask

task setup_sprite(input int spr, input hpos_t hs, input logic att, input word_t a,
	input word_t b);
	write_reg(spr, SPR_REG_POS, {8'h00, hs[8:1]});
	write_reg(spr, SPR_REG_CTL, {8'h00, att, 6'd0, hs[0]});
	write_reg(spr, SPR_REG_DATB, b);
	write_reg(spr, SPR_REG_DATA, a);  // arms last
endtask

task disarm_all;
	for (int i = 0; i < SPR_NUM; i++)
		write_reg(i, SPR_REG_CTL, 16'h0000);
endtask

task wait_hpos(input hpos_t target);
	int cycles;
	cycles = 0;
	@(negedge clk);
	while (hpos != target)
	begin
		if (cycles >= WAIT_LIMIT)
			stop_run($sformatf("timeout: beam never reached position %0d", target));
		cycles++;
		@(negedge clk);
	end
endtask

// run to the end of this line, stop early in the next
task next_line;
	wait_hpos(LINE_LEN - 9'd1);
	wait_hpos(9'd1);
endtask

// follow hpos one step at a time until it wraps
task check_beam_line;
	hpos_t prev;
	hpos_t expect_pos;
	int cycles;
	logic wrapped;
	prev = hpos;
	cycles = 0;
	wrapped = 1'b0;
	while (!wrapped)
	begin
		@(negedge clk);
		cycles++;
		if (cycles > WAIT_LIMIT)
			stop_run("timeout: beam counter did not wrap within one line");
		if (hpos != prev)
		begin
			expect_pos = (prev == LINE_LEN - 9'd1) ? 9'd0 : prev + 9'd1;
			if (hpos != expect_pos)
				stop_run($sformatf("CHECK FAILED at %0t: hpos %0d, expected %0d",
					$time, hpos, expect_pos));
			wrapped = (hpos == 9'd0);
			prev = hpos;
		end
	end
endtask

// ----------------------------------------------------------------------
// stimulus
// ----------------------------------------------------------------------
initial
begin
	hpos_t hs;
	for (int i = 0; i < SPR_NUM; i++)
	begin
		m_hstart[i] = '0;
		m_attach[i] = 1'b0;
		m_a[i] = '0;
		m_b[i] = '0;
		m_armed[i] = 1'b0;
	end
	repeat (2) @(posedge clk);
	rst <= 1'b0;
	@(negedge clk);
	if (hpos != 9'd0)
		stop_run($sformatf("CHECK FAILED at %0t: hpos %0d after reset", $time, hpos));

	// idle line, outputs stay 0, beam wraps
	check_beam_line();

	// single sprite, random words and start, shown on two lines
	hs = hpos_t'(40 + ($unsigned($random(seed)) % 380));
	setup_sprite(3, hs, 1'b0, word_t'($random(seed)), word_t'($random(seed)));
	next_line();
	next_line();

	// overlaps across pairs and inside pair 0
	disarm_all();
	setup_sprite(2, 9'd100, 1'b0, 16'hFF00, 16'h0FF0);
	setup_sprite(5, 9'd106, 1'b0, 16'hFFFF, 16'hAAAA);  // under sprite 2
	setup_sprite(0, 9'd200, 1'b0, 16'hF0F0, 16'h0000);  // gaps show sprite 1
	setup_sprite(1, 9'd196, 1'b0, 16'hFFFF, 16'hFF00);
	next_line();

	// attached pair 4/5 over pair 3
	disarm_all();
	setup_sprite(4, 9'd150, 1'b0, word_t'($random(seed)), word_t'($random(seed)));
	setup_sprite(5, 9'd150, 1'b1, word_t'($random(seed)), word_t'($random(seed)));
	setup_sprite(7, 9'd154, 1'b0, 16'hFFFF, 16'hFFFF);
	next_line();

	// sprites armed but masked off
	@(posedge clk);
	sprena <= 1'b0;
	next_line();
	@(posedge clk);
	sprena <= 1'b1;

	// ctl disarms sprite 5 until data comes again
	write_reg(5, SPR_REG_CTL, 16'h0080);  // same attach and hstart bit
	next_line();
	next_line();
	write_reg(5, SPR_REG_DATA, word_t'($random(seed)));
	next_line();

	$display("TESTBENCH PASSED");
	$finish;
end

endmodule

// File: verilog/denise_sprites.sv
/*
 * Sprite section of Denise: address decode, eight shifters, priority.
 * Registers sit at SPR_BASE, 8 bytes per sprite, written on clk7_en.
 * No DMA and no vertical control, data registers are written directly.
 */

`timescale 1ns/10ps

module denise_sprites
	import sprite_pkg::*;
(
	input  logic       clk,             // 28 MHz
	input  logic       clk7_en,         // lores pixel tick
	input  logic       rst,             // sync, active high
	input  reg_addr_t  reg_address_in,  // register address
	input  hpos_t      hpos,            // horizontal beam counter
	input  word_t      data_in,         // bus data
	input  logic       sprena,          // sprite enable
	output spr_mask_t  nsprite,         // opaque sprite mask
	output spr_color_t sprdata          // sprite colour
);

// ----------------------------------------------------------------------
// local signals
// ----------------------------------------------------------------------
logic                   sel_base;     // address in sprite range
spr_mask_t              sel;          // one select per sprite
spr_pix_t [SPR_NUM-1:0] spr_pix;      // shifter outputs
spr_mask_t              spr_attach;   // even bits not used by priority

// ----------------------------------------------------------------------
// address decoder
// ----------------------------------------------------------------------
assign sel_base = (reg_address_in[8:6] == SPR_BASE[8:6]);

always_comb
begin
	for (int i = 0; i < SPR_NUM; i++)
		sel[i] = sel_base && (reg_address_in[5:3] == 3'(i));  // sprite number
end

// ----------------------------------------------------------------------
// sprite shifters
// ----------------------------------------------------------------------
for (genvar i = 0; i < SPR_NUM; i++)
begin : g_spr
	sprite_shifter u_shifter
	(
		.clk     (clk),
		.clk7_en (clk7_en),
		.rst     (rst),
		.aen     (sel[i]),
		.address (reg_address_in[2:1]),  // register offset
		.hpos    (hpos),
		.data_in (data_in),
		.sprdata (spr_pix[i]),
		.attach  (spr_attach[i])
	);
end

// ----------------------------------------------------------------------
// priority and colour
// ----------------------------------------------------------------------
sprite_priority u_priority
(
	.sprena  (sprena),
	.sprdat0 (spr_pix[0]),
	.sprdat1 (spr_pix[1]),
	.sprdat2 (spr_pix[2]),
	.sprdat3 (spr_pix[3]),
	.sprdat4 (spr_pix[4]),
	.sprdat5 (spr_pix[5]),
	.sprdat6 (spr_pix[6]),
	.sprdat7 (spr_pix[7]),
	.attach1 (spr_attach[1]),  // odd sprite of each pair decides
	.attach3 (spr_attach[3]),
	.attach5 (spr_attach[5]),
	.attach7 (spr_attach[7]),
	.nsprite (nsprite),
	.sprdata (sprdata)
);

endmodule

// File: verilog/sprite_display.sv
/*
 * Sprite display top: 7 MHz pixel enable, beam counter, sprite block.
 * clk is 28 MHz; clk7_en fires every 4th clk, first in the 4th after reset.
 * hpos wraps at LINE_LEN; bus master holds address and data 4 clk or more.
 */

`timescale 1ns/10ps

module sprite_display
	import sprite_pkg::*;
(
	input  logic       clk,             // 28 MHz
	input  logic       rst,             // sync, active high
	input  reg_addr_t  reg_address_in,  // register address, IDLE_ADDR when idle
	input  word_t      data_in,         // bus data
	input  logic       sprena,          // sprite enable
	output hpos_t      hpos,            // beam position for the rest of the chip
	output spr_mask_t  nsprite,         // opaque sprite mask
	output spr_color_t sprdata          // sprite colour
);

// ----------------------------------------------------------------------
// pixel enable divider
// ----------------------------------------------------------------------
logic [1:0] div_cnt;  // 28 MHz / 4
logic       clk7_en;  // lores pixel tick

always_ff @(posedge clk)
begin
	if (rst)
		div_cnt <= 2'd0;
	else
		div_cnt <= div_cnt + 2'd1;
end

assign clk7_en = (div_cnt == 2'd3);

// ----------------------------------------------------------------------
// horizontal beam counter
// ----------------------------------------------------------------------
always_ff @(posedge clk)
begin
	if (rst)
		hpos <= '0;
	else if (clk7_en)
	begin
		if (hpos == LINE_LEN - 9'd1)
			hpos <= '0;  // end of line
		else
			hpos <= hpos + 9'd1;
	end
end

a_hpos_range: assert property (@(posedge clk) disable iff (rst) hpos < LINE_LEN)
	else $error("hpos %0d past end of line at %0t", hpos, $time);

// ----------------------------------------------------------------------
// sprites
// ----------------------------------------------------------------------
denise_sprites u_sprites
(
	.clk            (clk),
	.clk7_en        (clk7_en),
	.rst            (rst),
	.reg_address_in (reg_address_in),
	.hpos           (hpos),
	.data_in        (data_in),
	.sprena         (sprena),
	.nsprite        (nsprite),
	.sprdata        (sprdata)
);

endmodule

// File: verilog/sprite_pkg.sv
/*
 * Shared types and register map of the OCS sprite block.
 * Sprite count, register layout and line length are fixed by the chip.
 * Addresses are word addresses, bit 0 of the byte address is not carried.
 */

package sprite_pkg;

	// ------------------------------------------------------------------
	// widths with a meaning
	// ------------------------------------------------------------------
	typedef logic [8:1] reg_addr_t;   // register address bus, word aligned
	typedef logic [8:0] hpos_t;       // beam position, lores pixels
	typedef logic [15:0] word_t;      // bus data word
	typedef logic [1:0] spr_pix_t;    // one sprite pixel, 0 = transparent
	typedef logic [3:0] spr_color_t;  // merged sprite colour index
	typedef logic [7:0] spr_mask_t;   // one bit per sprite

	// arm state of one sprite shifter
	typedef enum logic
	{
		SPR_DISARMED,  // no start compare, CTL write or reset
		SPR_ARMED      // fires on every line at hstart
	} spr_state_t;

	// ------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------
	// sprite registers start here, 8 bytes per sprite
	localparam logic [8:0] SPR_BASE = 9'h140;
	localparam int SPR_NUM = 8;        // hardware sprites

	// word offsets inside one sprite
	localparam logic [1:0] SPR_REG_POS = 2'd0;   // hstart high bits
	localparam logic [1:0] SPR_REG_CTL = 2'd1;   // hstart lsb, attach, disarm
	localparam logic [1:0] SPR_REG_DATA = 2'd2;  // word A, arms
	localparam logic [1:0] SPR_REG_DATB = 2'd3;  // word B

	// address that hits no sprite register
	// bus rests here between writes
	localparam logic [8:0] IDLE_ADDR = 9'h1FE;

	// ------------------------------------------------------------------
	// beam
	// ------------------------------------------------------------------
	// hpos runs 0 .. LINE_LEN-1 then wraps
	localparam hpos_t LINE_LEN = 9'd455;

endpackage

// File: verilog/sprite_priority.sv
/*
 * Sprite priority and colour decode, purely combinational.
 * Lower pair wins; inside a pair the even sprite wins unless attached.
 * Attach comes from the odd sprite of each pair only.
 */

`timescale 1ns/10ps

module sprite_priority
	import sprite_pkg::*;
(
	input  logic       sprena,   // sprite enable
	input  spr_pix_t   sprdat0,  // pixels of sprites 0..7
	input  spr_pix_t   sprdat1,
	input  spr_pix_t   sprdat2,
	input  spr_pix_t   sprdat3,
	input  spr_pix_t   sprdat4,
	input  spr_pix_t   sprdat5,
	input  spr_pix_t   sprdat6,
	input  spr_pix_t   sprdat7,
	input  logic       attach1,  // pair 0,1 attached
	input  logic       attach3,  // pair 2,3 attached
	input  logic       attach5,  // pair 4,5 attached
	input  logic       attach7,  // pair 6,7 attached
	output spr_mask_t  nsprite,  // opaque sprite mask
	output spr_color_t sprdata   // merged colour
);

spr_pix_t [SPR_NUM-1:0] pix;  // pixels indexed by sprite number
logic [3:0] pair_attach;      // attach per pair

assign pix = {sprdat7, sprdat6, sprdat5, sprdat4, sprdat3, sprdat2, sprdat1, sprdat0};
assign pair_attach = {attach7, attach5, attach3, attach1};

// ----------------------------------------------------------------------
// opacity mask
// ----------------------------------------------------------------------
always_comb
begin
	for (int i = 0; i < SPR_NUM; i++)
		nsprite[i] = sprena && (pix[i] != 2'b00);  // any set bit is opaque
end

// ----------------------------------------------------------------------
// priority and colour
// ----------------------------------------------------------------------
// walk from the highest pair down so the lowest opaque pair is left
always_comb
begin
	sprdata = '0;  // all transparent
	for (int p = SPR_NUM/2 - 1; p >= 0; p--)
	begin
		if (nsprite[2*p +: 2] != 2'b00)
		begin
			if (pair_attach[p])
				sprdata = {pix[2*p+1], pix[2*p]};   // 15 colours + transparent
			else if (nsprite[2*p])
				sprdata = {2'(p), pix[2*p]};        // even sprite in front
			else
				sprdata = {2'(p), pix[2*p+1]};      // odd sprite
		end
	end
end

// ----------------------------------------------------------------------
// checks
// ----------------------------------------------------------------------
always_comb
begin
	a_mask_off: assert (sprena || nsprite == '0)
		else $error("nsprite %b while sprena low", nsprite);
	// colour 0 exactly when nothing is opaque
	a_color_off: assert ((nsprite == '0) == (sprdata == '0))
		else $error("sprdata %h does not match opaque mask %b", sprdata, nsprite);
end

endmodule

// File: verilog/sprite_shifter.sv
/*
 * One OCS sprite: POS/CTL/DATA/DATB registers, arm state and serialiser.
 * Writes land on the clk7_en tick, so the bus must hold for one tick.
 * Pixels appear from hstart+1 on, MSB first; vertical control not handled.
 */

`timescale 1ns/10ps

module sprite_shifter
	import sprite_pkg::*;
(
	input  logic       clk,      // 28 MHz
	input  logic       clk7_en,  // lores pixel tick
	input  logic       rst,      // sync, active high
	input  logic       aen,      // this sprite selected by decoder
	input  logic [1:0] address,  // register offset inside sprite
	input  hpos_t      hpos,     // beam position
	input  word_t      data_in,  // bus data
	output spr_pix_t   sprdata,  // {B, A} serial pixel
	output logic       attach    // CTL bit 7
);

// ----------------------------------------------------------------------
// local signals
// ----------------------------------------------------------------------
hpos_t      hstart;         // horizontal start position
word_t      data_a;         // DATA register
word_t      data_b;         // DATB register
spr_state_t state;          // arm state
word_t      shift_a;        // serialiser, low pixel bit
word_t      shift_b;        // serialiser, high pixel bit
logic       wr_en;          // register write this tick
logic       start_hit;      // beam at hstart on a tick
logic       load;           // start while armed
logic       armed_at_load;  // arm state seen at last start compare

assign wr_en = clk7_en && aen;
assign start_hit = clk7_en && (hpos == hstart);
assign load = start_hit && (state == SPR_ARMED);

// ----------------------------------------------------------------------
// register writes
// ----------------------------------------------------------------------
always_ff @(posedge clk)
begin
	if (rst)
	begin
		hstart <= '0;
		attach <= 1'b0;
		data_a <= '0;
		data_b <= '0;
	end
	else if (wr_en)
	begin
		case (address)
			SPR_REG_POS:
				hstart[8:1] <= data_in[7:0];  // SPRxPOS low byte
			SPR_REG_CTL:
			begin
				hstart[0] <= data_in[0];  // half-pixel bit
				attach <= data_in[7];     // only odd sprites' bit is used
			end
			SPR_REG_DATA:
				data_a <= data_in;
			SPR_REG_DATB:
				data_b <= data_in;
		endcase
	end
end

// arm state
// CTL write disarms, DATA write arms, nothing else changes it
always_ff @(posedge clk)
begin
	if (rst)
		state <= SPR_DISARMED;
	else if (wr_en && address == SPR_REG_CTL)
		state <= SPR_DISARMED;
	else if (wr_en && address == SPR_REG_DATA)
		state <= SPR_ARMED;
end

// ----------------------------------------------------------------------
// serialiser
// ----------------------------------------------------------------------
// load at hstart, then shift one pixel per tick with zero fill
// so the sprite goes transparent after 16 pixels
always_ff @(posedge clk)
begin
	if (rst)
	begin
		shift_a <= '0;
		shift_b <= '0;
	end
	else if (load)
	begin
		shift_a <= data_a;  // old word if DATA written on the same tick
		shift_b <= data_b;
	end
	else if (clk7_en)
	begin
		shift_a <= {shift_a[14:0], 1'b0};
		shift_b <= {shift_b[14:0], 1'b0};
	end
end

assign sprdata = {shift_b[15], shift_a[15]};  // B is the high bit

// remember whether the last start compare was armed
always_ff @(posedge clk)
begin
	if (rst)
		armed_at_load <= 1'b0;
	else if (start_hit)
		armed_at_load <= (state == SPR_ARMED);
end

// ----------------------------------------------------------------------
// checks
// ----------------------------------------------------------------------
// a visible pixel must come from a start that saw the sprite armed
a_pix_from_armed: assert property (@(posedge clk) disable iff (rst)
	(sprdata != 2'b00) |-> armed_at_load)
	else $error("sprite pixel %b without armed start at %0t", sprdata, $time);

endmodule
